// File: Bender.yml
package:
  name: pe_array

sources:
  - include_dirs:
      - include
    files:
      - hw/pe_types_pkg.sv
      - hw/reduce_ctrl_pkg.sv
      - hw/pe_unit.sv
      - hw/col_counter.sv
      - hw/reduce_fsm.sv
      - hw/row_accumulator.sv
      - hw/result_reduce.sv
      - hw/pe_array_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/pe_array_tb.sv

// File: hw/col_counter.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module col_counter (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic step,
    output logic col_first,
    output logic col_last
);

    logic [`PE_COL_W-1:0] count;
    // set once the last column of the job has gone by
    logic                 wrapped;

    assign col_first = (count == '0);
    assign col_last  = (count == (`PE_COLS - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count   <= '0;
            wrapped <= 1'b0;
        end else if (clear) begin
            count   <= '0;
            wrapped <= 1'b0;
        end else if (step) begin
            count <= count + 1'b1;
            if (col_last) begin
                wrapped <= 1'b1;
            end
        end
    end

    no_step_past_last: assert property (
        @(posedge clk) disable iff (!rst) !(step && wrapped && !clear)
    ) else $error("column step after the last column of the job");

endmodule

// File: hw/pe_array_top.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_array_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  reduce_ctrl_pkg::reduce_mode_e mode,
    input  logic                          col_load,
    input  pe_types_pkg::row_lanes_t      in_data,
    input  pe_types_pkg::row_lanes_t      par_data,
    output logic                          busy,
    output logic                          out_valid,
    output pe_types_pkg::row_scalar_t     scalar_out,
    output pe_types_pkg::row_vec_t        vec_out
);

    logic                          pe_en;
    logic                          pe_valid;
    logic                          emit;
    logic                          col_first;
    logic                          col_last;
    reduce_ctrl_pkg::reduce_mode_e mode_q;
    pe_types_pkg::row_scalar_t     pe_scalar;
    pe_types_pkg::row_vec_t        pe_vec;

    reduce_fsm reduce_fsm_inst (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .mode    (mode),
        .col_load(col_load),
        .pe_valid(pe_valid),
        .col_last(col_last),
        .busy    (busy),
        .pe_en   (pe_en),
        .emit    (emit),
        .mode_q  (mode_q)
    );

    col_counter col_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .clear    (start),
        .step     (pe_valid),
        .col_first(col_first),
        .col_last (col_last)
    );

    // all rows run in lockstep, row 0 supplies the valid
    for (genvar r = 0; r < `PE_ROWS; r++) begin : g_row
        if (r == 0) begin : g_lead
            pe_unit pe_unit_inst (
                .clk      (clk),
                .rst      (rst),
                .pe_en    (pe_en),
                .in_lanes (in_data[r]),
                .par_lanes(par_data[r]),
                .pe_valid (pe_valid),
                .pe_vec   (pe_vec[r]),
                .pe_scalar(pe_scalar[r])
            );
        end else begin : g_follow
            pe_unit pe_unit_inst (
                .clk      (clk),
                .rst      (rst),
                .pe_en    (pe_en),
                .in_lanes (in_data[r]),
                .par_lanes(par_data[r]),
                .pe_valid (),
                .pe_vec   (pe_vec[r]),
                .pe_scalar(pe_scalar[r])
            );
        end
    end

    result_reduce result_reduce_inst (
        .clk       (clk),
        .rst       (rst),
        .pe_valid  (pe_valid),
        .col_first (col_first),
        .emit      (emit),
        .mode_q    (mode_q),
        .pe_scalar (pe_scalar),
        .pe_vec    (pe_vec),
        .out_valid (out_valid),
        .scalar_out(scalar_out),
        .vec_out   (vec_out)
    );

endmodule

// File: hw/pe_types_pkg.sv
`include "pe_array_defines.svh"

package pe_types_pkg;

    // one data word
    typedef logic [`PE_WORD_W-1:0] word_t;

    // lane results of one processing element
    typedef word_t [`PE_LANES-1:0] lane_vec_t;

    // one column of inputs or parameters, row major
    typedef lane_vec_t [`PE_ROWS-1:0] row_lanes_t;

    // one scalar per row
    typedef word_t [`PE_ROWS-1:0] row_scalar_t;

    // one lane vector per row
    typedef lane_vec_t [`PE_ROWS-1:0] row_vec_t;

endpackage

// File: hw/pe_unit.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pe_en,
    input  pe_types_pkg::lane_vec_t in_lanes,
    input  pe_types_pkg::lane_vec_t par_lanes,
    output logic                  pe_valid,
    output pe_types_pkg::lane_vec_t pe_vec,
    output pe_types_pkg::word_t     pe_scalar
);

    pe_types_pkg::lane_vec_t prod;
    pe_types_pkg::word_t     dot;

    // products keep the low word only
    always_comb begin
        dot = '0;
        for (int l = 0; l < `PE_LANES; l++) begin
            prod[l] = in_lanes[l] * par_lanes[l];
            dot     = dot + prod[l];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pe_valid <= 1'b0;
        end else begin
            pe_valid <= pe_en;
        end
    end

    always_ff @(posedge clk) begin
        if (pe_en) begin
            pe_vec    <= prod;
            pe_scalar <= dot;
        end
    end

    // results stay defined while they are reported
    result_known: assert property (
        @(posedge clk) disable iff (!rst) pe_valid |-> !$isunknown({pe_vec, pe_scalar})
    ) else $error("pe_valid with undefined results");

endmodule

// File: hw/reduce_ctrl_pkg.sv
package reduce_ctrl_pkg;

    typedef enum logic [1:0] {
        mode_direct = 2'd0,
        mode_column = 2'd1,
        mode_row    = 2'd2,
        mode_all    = 2'd3
    } reduce_mode_e;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_drain = 2'd2
    } fsm_state_e;

endpackage

// File: hw/reduce_fsm.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module reduce_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  reduce_ctrl_pkg::reduce_mode_e mode,
    input  logic                        col_load,
    input  logic                        pe_valid,
    input  logic                        col_last,
    output logic                        busy,
    output logic                        pe_en,
    output logic                        emit,
    output reduce_ctrl_pkg::reduce_mode_e mode_q
);

    reduce_ctrl_pkg::fsm_state_e state;
    reduce_ctrl_pkg::fsm_state_e state_next;

    // accepted loads, separate from the reduce stage count
    logic [`PE_COL_W-1:0] load_cnt;
    logic                 last_load;
    logic                 accept_start;

    assign accept_start = start && (state == reduce_ctrl_pkg::st_idle);
    assign pe_en        = col_load && (state == reduce_ctrl_pkg::st_run);
    assign last_load    = pe_en && (load_cnt == (`PE_COLS - 1));
    assign busy         = (state == reduce_ctrl_pkg::st_run);

    always_comb begin
        state_next = state;
        case (state)
            reduce_ctrl_pkg::st_idle: begin
                if (start) begin
                    state_next = reduce_ctrl_pkg::st_run;
                end
            end
            reduce_ctrl_pkg::st_run: begin
                if (last_load) begin
                    state_next = reduce_ctrl_pkg::st_drain;
                end
            end
            reduce_ctrl_pkg::st_drain: begin
                // last column still in the PE stage
                if (pe_valid && col_last) begin
                    state_next = reduce_ctrl_pkg::st_idle;
                end
            end
            default: state_next = reduce_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= reduce_ctrl_pkg::st_idle;
            load_cnt <= '0;
            mode_q   <= reduce_ctrl_pkg::mode_direct;
        end else begin
            state <= state_next;
            if (accept_start) begin
                load_cnt <= '0;
                mode_q   <= mode;
            end else if (pe_en) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    // row and all modes report once per job
    always_comb begin
        case (mode_q)
            reduce_ctrl_pkg::mode_row,
            reduce_ctrl_pkg::mode_all: emit = pe_valid && col_last;
            default:                   emit = pe_valid;
        endcase
    end

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (!rst) busy |-> !start
    ) else $error("start raised while a job is running");

endmodule

// File: hw/result_reduce.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module result_reduce (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pe_valid,
    input  logic                          col_first,
    input  logic                          emit,
    input  reduce_ctrl_pkg::reduce_mode_e mode_q,
    input  pe_types_pkg::row_scalar_t     pe_scalar,
    input  pe_types_pkg::row_vec_t        pe_vec,
    output logic                          out_valid,
    output pe_types_pkg::row_scalar_t     scalar_out,
    output pe_types_pkg::row_vec_t        vec_out
);

    pe_types_pkg::row_scalar_t acc_scalar;
    pe_types_pkg::row_vec_t    acc_vec;
    pe_types_pkg::row_scalar_t tot_scalar;
    pe_types_pkg::row_vec_t    tot_vec;
    pe_types_pkg::word_t       col_scalar;
    pe_types_pkg::lane_vec_t   col_vec;
    pe_types_pkg::word_t       grand_scalar;
    pe_types_pkg::lane_vec_t   grand_vec;
    pe_types_pkg::row_scalar_t next_scalar;
    pe_types_pkg::row_vec_t    next_vec;

    for (genvar r = 0; r < `PE_ROWS; r++) begin : g_acc
        row_accumulator #(
            .payload_t(pe_types_pkg::word_t)
        ) scalar_acc_inst (
            .clk  (clk),
            .rst  (rst),
            .en   (pe_valid),
            .load (col_first),
            .value(pe_scalar[r]),
            .sum  (acc_scalar[r])
        );

        row_accumulator #(
            .payload_t(pe_types_pkg::lane_vec_t)
        ) vec_acc_inst (
            .clk  (clk),
            .rst  (rst),
            .en   (pe_valid),
            .load (col_first),
            .value(pe_vec[r]),
            .sum  (acc_vec[r])
        );
    end

    // row totals include the column being reported
    always_comb begin
        for (int r = 0; r < `PE_ROWS; r++) begin
            tot_scalar[r] = acc_scalar[r] + pe_scalar[r];
            for (int l = 0; l < `PE_LANES; l++) begin
                tot_vec[r][l] = acc_vec[r][l] + pe_vec[r][l];
            end
        end
    end

    // sums across rows, current column and whole job
    always_comb begin
        col_scalar   = '0;
        grand_scalar = '0;
        col_vec      = '0;
        grand_vec    = '0;
        for (int r = 0; r < `PE_ROWS; r++) begin
            col_scalar   = col_scalar + pe_scalar[r];
            grand_scalar = grand_scalar + tot_scalar[r];
            for (int l = 0; l < `PE_LANES; l++) begin
                col_vec[l]   = col_vec[l] + pe_vec[r][l];
                grand_vec[l] = grand_vec[l] + tot_vec[r][l];
            end
        end
    end

    always_comb begin
        next_scalar = '0;
        next_vec    = '0;
        case (mode_q)
            reduce_ctrl_pkg::mode_direct: begin
                next_scalar = pe_scalar;
                next_vec    = pe_vec;
            end
            reduce_ctrl_pkg::mode_column: begin
                next_scalar[0] = col_scalar;
                next_vec[0]    = col_vec;
            end
            reduce_ctrl_pkg::mode_row: begin
                next_scalar = tot_scalar;
                next_vec    = tot_vec;
            end
            default: begin
                // all mode, slot 0 carries the grand total
                next_scalar    = tot_scalar;
                next_vec       = tot_vec;
                next_scalar[0] = grand_scalar;
                next_vec[0]    = grand_vec;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            scalar_out <= '0;
            vec_out    <= '0;
        end else begin
            out_valid <= emit;
            if (emit) begin
                scalar_out <= next_scalar;
                vec_out    <= next_vec;
            end
        end
    end

endmodule

// File: hw/row_accumulator.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module row_accumulator #(
    parameter type payload_t = pe_types_pkg::word_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  logic     load,
    input  payload_t value,
    output payload_t sum
);

    localparam int unsigned width  = $bits(payload_t);
    localparam int unsigned word_w = `PE_WORD_W;
    localparam int unsigned lanes  = width / word_w;

    logic [width-1:0] acc;
    logic [width-1:0] acc_next;
    logic [width-1:0] value_bits;

    assign value_bits = value;
    assign sum        = acc;

    // lane-wise wrapping add
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            acc_next[l*word_w +: word_w] = acc[l*word_w +: word_w]
                                         + value_bits[l*word_w +: word_w];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc <= '0;
        end else if (en) begin
            acc <= load ? value_bits : acc_next;
        end
    end

endmodule

// File: include/pe_array_defines.svh
`ifndef PE_ARRAY_DEFINES_SVH
`define PE_ARRAY_DEFINES_SVH

// data word width, all arithmetic wraps here
`define PE_WORD_W 32

// lane pairs per processing element
`define PE_LANES 4

// array geometry
`define PE_ROWS 4
`define PE_COLS 8
`define PE_COL_W 3

`endif

// File: src.f
+incdir+include
hw/pe_types_pkg.sv
hw/reduce_ctrl_pkg.sv
hw/pe_unit.sv
hw/col_counter.sv
hw/reduce_fsm.sv
hw/row_accumulator.sv
hw/result_reduce.sv
hw/pe_array_top.sv
tests/pe_array_tb.sv

// File: tests/pe_array_tb.sv
`timescale 1ns/1ps
`include "pe_array_defines.svh"

module pe_array_tb;

    localparam int max_cycles = 20 * 12 + 50;

    logic                          clk;
    logic                          rst;
    logic                          start;
    reduce_ctrl_pkg::reduce_mode_e mode;
    logic                          col_load;
    pe_types_pkg::row_lanes_t      in_data;
    pe_types_pkg::row_lanes_t      par_data;
    logic                          busy;
    logic                          out_valid;
    pe_types_pkg::row_scalar_t     scalar_out;
    pe_types_pkg::row_vec_t        vec_out;

    integer seed = 81990;
    int     cyc = 0;
    int     pulses;

    // columns of the running job
    pe_types_pkg::row_lanes_t col_in [`PE_COLS];
    pe_types_pkg::row_lanes_t col_par [`PE_COLS];

    // expected results in arrival order
    int                        exp_cyc [$];
    pe_types_pkg::row_scalar_t exp_scalar [$];
    pe_types_pkg::row_vec_t    exp_vec [$];

    pe_array_top pe_array_top_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .mode      (mode),
        .col_load  (col_load),
        .in_data   (in_data),
        .par_data  (par_data),
        .busy      (busy),
        .out_valid (out_valid),
        .scalar_out(scalar_out),
        .vec_out   (vec_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= max_cycles) begin
            report_failure("timeout: run went past the cycle limit");
        end
    end

    // expected outputs straight from the reduce rules
    function automatic void ref_reduce(
        input  reduce_ctrl_pkg::reduce_mode_e m,
        input  int                            c,
        output pe_types_pkg::row_scalar_t     es,
        output pe_types_pkg::row_vec_t        ev
    );
        pe_types_pkg::word_t       p;
        pe_types_pkg::row_scalar_t tot_s;
        pe_types_pkg::row_vec_t    tot_v;
        pe_types_pkg::word_t       grand_s;
        pe_types_pkg::lane_vec_t   grand_v;
        int                        first;
        tot_s   = '0;
        tot_v   = '0;
        grand_s = '0;
        grand_v = '0;
        es      = '0;
        ev      = '0;
        // row and all cover the whole job
        first = (m == reduce_ctrl_pkg::mode_row || m == reduce_ctrl_pkg::mode_all) ? 0 : c;
        for (int k = first; k <= c; k++) begin
            for (int r = 0; r < `PE_ROWS; r++) begin
                for (int l = 0; l < `PE_LANES; l++) begin
                    p           = col_in[k][r][l] * col_par[k][r][l];
                    tot_v[r][l] = tot_v[r][l] + p;
                    tot_s[r]    = tot_s[r] + p;
                end
            end
        end
        for (int r = 0; r < `PE_ROWS; r++) begin
            grand_s = grand_s + tot_s[r];
            for (int l = 0; l < `PE_LANES; l++) begin
                grand_v[l] = grand_v[l] + tot_v[r][l];
            end
        end
        case (m)
            reduce_ctrl_pkg::mode_column: begin
                es[0] = grand_s;
                ev[0] = grand_v;
            end
            reduce_ctrl_pkg::mode_all: begin
                es    = tot_s;
                ev    = tot_v;
                es[0] = grand_s;
                ev[0] = grand_v;
            end
            default: begin
                es = tot_s;
                ev = tot_v;
            end
        endcase
    endfunction

    always @(negedge clk) begin : compare_outputs
        int                        exp_t;
        pe_types_pkg::row_scalar_t es;
        pe_types_pkg::row_vec_t    ev;
        if (rst && out_valid) begin
            assert (exp_cyc.size() != 0)
            else report_failure("out_valid pulse where no result was expected");
            exp_t = exp_cyc.pop_front();
            es    = exp_scalar.pop_front();
            ev    = exp_vec.pop_front();
            assert (cyc == exp_t)
            else report_failure($sformatf("out_valid at cycle %0d, expected at %0d", cyc, exp_t));
            for (int r = 0; r < `PE_ROWS; r++) begin
                assert (scalar_out[r] == es[r])
                else report_failure($sformatf("MISMATCH scalar_out[%0d] got %h expected %h",
                                              r, scalar_out[r], es[r]));
                for (int l = 0; l < `PE_LANES; l++) begin
                    assert (vec_out[r][l] == ev[r][l])
                    else report_failure($sformatf("MISMATCH vec_out[%0d][%0d] got %h expected %h",
                                                  r, l, vec_out[r][l], ev[r][l]));
                end
            end
            pulses = pulses + 1;
        end
    end

    task automatic fill_column(input int c, input bit big);
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int l = 0; l < `PE_LANES; l++) begin
                col_in[c][r][l]  = $random(seed);
                col_par[c][r][l] = $random(seed);
                // push the top bits so sums wrap
                if (big) begin
                    col_in[c][r][l]  = col_in[c][r][l] | 32'hf000_0000;
                    col_par[c][r][l] = col_par[c][r][l] | 32'hf000_0000;
                end
            end
        end
    endtask

    task automatic run_job(input reduce_ctrl_pkg::reduce_mode_e m, input int gap, input bit big);
        pe_types_pkg::row_scalar_t es;
        pe_types_pkg::row_vec_t    ev;
        int                        n_exp;
        int                        last_t;
        n_exp  = 0;
        last_t = 0;
        @(posedge clk);
        start <= 1'b1;
        mode  <= m;
        @(posedge clk);
        start  <= 1'b0;
        pulses = 0;
        for (int c = 0; c < `PE_COLS; c++) begin
            fill_column(c, big);
            in_data  <= col_in[c];
            par_data <= col_par[c];
            col_load <= 1'b1;
            if (m == reduce_ctrl_pkg::mode_direct || m == reduce_ctrl_pkg::mode_column
                || c == `PE_COLS - 1) begin
                ref_reduce(m, c, es, ev);
                last_t = cyc + 3;
                exp_cyc.push_back(last_t);
                exp_scalar.push_back(es);
                exp_vec.push_back(ev);
                n_exp++;
            end
            @(negedge clk);
            assert (busy) else report_failure("busy low while columns are loaded");
            @(posedge clk);
            if (gap > 0) begin
                col_load <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        col_load <= 1'b0;
        // last result is due two cycles after its load
        while (cyc <= last_t) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        assert (pulses == n_exp)
        else report_failure($sformatf("job gave %0d out_valid pulses, expected %0d",
                                      pulses, n_exp));
        assert (!busy) else report_failure("busy still high after the job ended");
    endtask

    // a load outside a job must be dropped
    task automatic idle_load();
        @(posedge clk);
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int l = 0; l < `PE_LANES; l++) begin
                in_data[r][l]  <= $random(seed);
                par_data[r][l] <= $random(seed);
            end
        end
        col_load <= 1'b1;
        @(posedge clk);
        col_load <= 1'b0;
        repeat (4) @(negedge clk);
        assert (!busy) else report_failure("col_load while idle started a job");
    endtask

    initial begin
        rst      = 1'b0;
        start    = 1'b0;
        mode     = reduce_ctrl_pkg::mode_direct;
        col_load = 1'b0;
        in_data  = '0;
        par_data = '0;
        pulses   = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        assert (!busy && !out_valid) else report_failure("busy or out_valid high after reset");
        assert (scalar_out == '0) else report_failure("scalar_out not zero after reset");
        assert (vec_out == '0) else report_failure("vec_out not zero after reset");

        run_job(reduce_ctrl_pkg::mode_direct, 0, 1'b0);
        run_job(reduce_ctrl_pkg::mode_column, 2, 1'b0);
        run_job(reduce_ctrl_pkg::mode_row, 0, 1'b1);
        idle_load();
        run_job(reduce_ctrl_pkg::mode_all, 1, 1'b0);

        // jobs back to back, mode changes each time
        run_job(reduce_ctrl_pkg::mode_row, 0, 1'b0);
        run_job(reduce_ctrl_pkg::mode_all, 0, 1'b1);
        run_job(reduce_ctrl_pkg::mode_direct, 1, 1'b0);
        run_job(reduce_ctrl_pkg::mode_column, 0, 1'b1);

        $display("sim passed");
        $finish;
    end

endmodule
